/* compile.f */
src/cpu_pkg.sv
src/main_decoder.sv
src/alu_decoder.sv
src/alu.sv
src/reg_file.sv
src/pc_unit.sv
src/datapath.sv
src/cpu_top.sv
testbench/tb_cpu.sv

/* Makefile */
SRCS := $(wildcard src/*.sv testbench/*.sv)

.PHONY: all run clean

all: obj_dir/Vtb_cpu

obj_dir/Vtb_cpu: compile.f $(SRCS)
	verilator --binary --timescale 1ns/100ps --top-module tb_cpu -f compile.f

run: obj_dir/Vtb_cpu
	./obj_dir/Vtb_cpu | tee sim.log
	grep -q "Test completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log

/* testbench/tb_cpu.sv */
// Directed testbench for cpu_top. Memories model 256 words and each program ends on a halt word.
`timescale 1ns/100ps

module tb_cpu;
  import cpu_pkg::*;

  localparam int    CLK_HALF     = 4;  // 8 ns period
  localparam int    RESET_CYCLES = 10;
  localparam int    RUN_BUDGET   = 40; // Cycles allowed per program
  localparam int    PROGRAM_RUNS = 8;
  localparam int    HALT_WATCH   = 6;
  localparam int    TOTAL_CYCLES = PROGRAM_RUNS * (RESET_CYCLES + 2 + RUN_BUDGET) + HALT_WATCH;
  localparam word_t HALT_WORD    = {6'b111111, 26'd0}; // Opcode the core does not know

  logic  clk;
  logic  reset;
  word_t imem_data, dmem_rdata, imem_addr, dmem_addr, dmem_wdata;
  logic  dmem_we, halted;

  word_t prog [256];
  word_t dmem [256];
  word_t fetch_log [$];  // Every executed address
  word_t store_addr [$];
  word_t store_data [$];
  int    fetch_base, store_base; // Start of the current program in the logs
  logic  we_in_reset = 1'b0;     // Sticky
  int    errors = 0, checks = 0;

  cpu_top u_dut (
    .clk (clk), .reset (reset), .imem_data (imem_data), .dmem_rdata (dmem_rdata),
    .imem_addr (imem_addr), .dmem_addr (dmem_addr), .dmem_wdata (dmem_wdata),
    .dmem_we (dmem_we), .halted (halted)
  );

  // Combinational word-addressed memories
  assign imem_data  = prog[imem_addr[9:2]];
  assign dmem_rdata = dmem[dmem_addr[9:2]];

  initial begin
    clk = 1'b0;
    forever #CLK_HALF clk = ~clk;
  end

  // ----------------------------------------------------------------------
  // Encoders and reference rules
  // ----------------------------------------------------------------------
  function automatic word_t dmem_fill(int index);
    return word_t'(index) * 32'h9E37_79B9 + 32'h0BAD_F00D; // Whole index mixed in
  endfunction

  function automatic word_t r_type(funct_t funct, reg_addr_t rd, reg_addr_t rs, reg_addr_t rt);
    return {OP_RTYPE, rs, rt, rd, 5'd0, funct};
  endfunction

  function automatic word_t i_type(opcode_t op, reg_addr_t rt, reg_addr_t rs, logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic word_t j_type(opcode_t op, logic [25:0] index);
    return {op, index};
  endfunction

  function automatic word_t branch_dest(word_t pc, logic [15:0] offset);
    return pc + 32'd4 + {{14{offset[15]}}, offset, 2'b00}; // Offset in words from pc+4
  endfunction

  function automatic word_t jump_dest(word_t pc, logic [25:0] index);
    word_t next;
    next = pc + 32'd4;
    return {next[31:28], index, 2'b00}; // Region of pc+4
  endfunction

  // Data memory writes, store log and fetch log
  always @(posedge clk) begin
    if (reset) begin
      if (dmem_we) begin
        we_in_reset <= 1'b1;
      end
      for (int i = 0; i < 256; i++) begin
        dmem[i] <= dmem_fill(i); // Preset contents
      end
    end else begin
      fetch_log.push_back(imem_addr);
      if (dmem_we) begin
        store_addr.push_back(dmem_addr);
        store_data.push_back(dmem_wdata);
        dmem[dmem_addr[9:2]] <= dmem_wdata;
      end
    end
  end

  // Watchdog
  initial begin
    #(2 * TOTAL_CYCLES * 2 * CLK_HALF);
    $display("Watchdog expired after %0d cycles, the simulation hung", 2 * TOTAL_CYCLES);
    $display("Test failed");
    $finish;
  end

  // ----------------------------------------------------------------------
  // Compare tasks
  // ----------------------------------------------------------------------
  task automatic check_word(input word_t got, input word_t exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED at %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_fetch(input int n, input word_t exp);
    if (fetch_base + n >= fetch_log.size()) begin
      errors++;
      $display("Fetch number %0d of the program never happened", n);
    end else begin
      check_word(fetch_log[fetch_base + n], exp, $sformatf("fetch %0d", n));
    end
  endtask

  task automatic check_store(input int n, input word_t addr, input word_t data);
    if (store_base + n >= store_addr.size()) begin
      errors++;
      $display("Store number %0d of the program never happened", n);
    end else begin
      check_word(store_addr[store_base + n], addr, $sformatf("store %0d address", n));
      check_word(store_data[store_base + n], data, $sformatf("store %0d data", n));
    end
  endtask

  task automatic check_store_count(input int n);
    check_word(word_t'(store_addr.size() - store_base), word_t'(n), "store count");
  endtask

  // ----------------------------------------------------------------------
  // Reset and run control
  // ----------------------------------------------------------------------
  task automatic start_reset();
    @(posedge clk);
    reset <= 1'b1;
    @(posedge clk); // Core now in reset so the program may change
    for (int i = 0; i < 256; i++) begin
      prog[i] = {6'h3F, 26'(i)}; // Halts if run into
    end
  endtask

  task automatic end_reset();
    repeat (RESET_CYCLES - 1) @(posedge clk);
    reset <= 1'b0;
    fetch_base = fetch_log.size();
    store_base = store_addr.size();
  endtask

  task automatic run_until_halt();
    int cycles;
    cycles = 0;
    do begin
      @(negedge clk);
      cycles++;
    end while (!halted && cycles < RUN_BUDGET);
    if (!halted) begin
      errors++;
      $display("Program did not reach its halt word within %0d cycles", RUN_BUDGET);
    end
    @(negedge clk); // Halt fetch now in the log
  endtask

  // ----------------------------------------------------------------------
  // Directed tests
  // ----------------------------------------------------------------------
  task automatic reset_then_straight_line();
    start_reset();
    prog[0] = i_type(OP_SW, 5'd0, 5'd0, 16'd0); // Store on the bus through reset
    prog[1] = i_type(OP_ADDI, 5'd1, 5'd0, 16'd1);
    prog[2] = i_type(OP_ADDI, 5'd2, 5'd1, 16'd2);
    prog[3] = r_type(FUNCT_ADD, 5'd3, 5'd1, 5'd2);
    prog[4] = r_type(FUNCT_OR, 5'd4, 5'd3, 5'd1);
    prog[5] = i_type(OP_ADDI, 5'd5, 5'd4, 16'd9);
    prog[6] = HALT_WORD;
    end_reset();
    run_until_halt();
    check_bit(we_in_reset, 1'b0, "dmem_we seen in reset");
    for (int n = 0; n < 7; n++) begin
      check_fetch(n, word_t'(n) * 32'd4); // From 0 in steps of 4
    end
    check_store_count(1);
    check_store(0, 32'd0, 32'd0);
  endtask

  task automatic arith_stores();
    logic [15:0] imm_a, imm_b;
    word_t       a, b, diff;
    imm_a = 16'($urandom);
    imm_b = 16'($urandom);
    a     = {{16{imm_a[15]}}, imm_a}; // addi sign-extends
    b     = {{16{imm_b[15]}}, imm_b};
    diff  = a - b;
    start_reset();
    prog[0] = i_type(OP_ADDI, 5'd1, 5'd0, imm_a);
    prog[1] = i_type(OP_ADDI, 5'd2, 5'd0, imm_b);
    prog[2] = r_type(FUNCT_ADD, 5'd3, 5'd1, 5'd2);
    prog[3] = r_type(FUNCT_SUB, 5'd4, 5'd1, 5'd2);
    prog[4] = r_type(FUNCT_AND, 5'd5, 5'd1, 5'd2);
    prog[5] = r_type(FUNCT_OR, 5'd6, 5'd1, 5'd2);
    prog[6] = r_type(FUNCT_SLT, 5'd7, 5'd1, 5'd2);
    for (int k = 0; k < 5; k++) begin
      prog[7 + k] = i_type(OP_SW, reg_addr_t'(k + 3), 5'd0, 16'(4 * k)); // r3..r7 to 0..16
    end
    prog[12] = HALT_WORD;
    end_reset();
    run_until_halt();
    check_store_count(5);
    check_store(0, 32'd0, a + b);
    check_store(1, 32'd4, diff);
    check_store(2, 32'd8, a & b);
    check_store(3, 32'd12, a | b);
    check_store(4, 32'd16, {31'd0, diff[31]}); // Sign of the difference
  endtask

  task automatic load_and_zero_reg();
    start_reset();
    prog[0] = i_type(OP_ADDI, 5'd3, 5'd0, 16'd16); // Base register
    prog[1] = i_type(OP_LW, 5'd1, 5'd3, 16'd16);   // Word 8
    prog[2] = i_type(OP_ADDI, 5'd2, 5'd1, 16'd100);
    prog[3] = i_type(OP_SW, 5'd2, 5'd0, 16'd36);
    prog[4] = i_type(OP_ADDI, 5'd0, 5'd0, 16'd55); // Must be dropped
    prog[5] = i_type(OP_SW, 5'd0, 5'd0, 16'd40);
    prog[6] = HALT_WORD;
    end_reset();
    run_until_halt();
    check_store_count(2);
    check_store(0, 32'd36, dmem_fill(8) + 32'd100);
    check_store(1, 32'd40, 32'd0);
  endtask

  task automatic branch_and_jump();
    word_t exp_pc [6];
    start_reset();
    prog[0] = i_type(OP_ADDI, 5'd1, 5'd0, 16'd5);
    prog[1] = i_type(OP_ADDI, 5'd2, 5'd0, 16'd5);
    prog[2] = i_type(OP_BEQ, 5'd2, 5'd1, 16'd2);  // Equal and taken
    prog[3] = i_type(OP_SW, 5'd1, 5'd0, 16'd0);   // Skipped
    prog[4] = i_type(OP_SW, 5'd1, 5'd0, 16'd4);   // Skipped
    prog[5] = i_type(OP_BEQ, 5'd0, 5'd1, 16'd5);  // Unequal so it falls through
    prog[6] = j_type(OP_J, 26'd9);
    prog[7] = i_type(OP_SW, 5'd2, 5'd0, 16'd8);   // Skipped
    prog[9] = HALT_WORD;
    exp_pc[0] = 32'd0;
    exp_pc[1] = 32'd4;
    exp_pc[2] = 32'd8;
    exp_pc[3] = branch_dest(exp_pc[2], 16'd2);
    exp_pc[4] = exp_pc[3] + 32'd4;
    exp_pc[5] = jump_dest(exp_pc[4], 26'd9);
    end_reset();
    run_until_halt();
    for (int n = 0; n < 6; n++) begin
      check_fetch(n, exp_pc[n]);
    end
    check_store_count(0);
  endtask

  task automatic call_and_return();
    word_t jal_addr;
    jal_addr = 32'd4;
    start_reset();
    prog[0] = i_type(OP_ADDI, 5'd1, 5'd0, 16'd7);
    prog[1] = j_type(OP_JAL, 26'd5);
    prog[2] = i_type(OP_SW, 5'd1, 5'd0, 16'd48);  // After return
    prog[3] = HALT_WORD;
    prog[5] = i_type(OP_SW, 5'd31, 5'd0, 16'd44); // Subroutine saves ra
    prog[6] = i_type(OP_JR, 5'd0, 5'd31, 16'd0);
    end_reset();
    run_until_halt();
    check_fetch(2, jump_dest(jal_addr, 26'd5));
    check_fetch(4, jal_addr + 32'd4);             // Fetch after jr
    check_store_count(2);
    check_store(0, 32'd44, jal_addr + 32'd4);
    check_store(1, 32'd48, 32'd7);
  endtask

  task automatic halt_freezes_fetch();
    word_t halt_addr;
    start_reset();
    prog[0] = i_type(OP_ADDI, 5'd1, 5'd0, 16'd3);
    prog[1] = {6'b111101, 5'd1, 5'd2, 16'h0030};  // Unknown opcode
    prog[2] = i_type(OP_SW, 5'd1, 5'd0, 16'd0);   // Never reached
    end_reset();
    run_until_halt();
    halt_addr = imem_addr;
    check_word(halt_addr, 32'd4, "halt address");
    repeat (HALT_WATCH) begin
      @(negedge clk);
      check_word(imem_addr, halt_addr, "imem_addr while halted");
      check_bit(halted, 1'b1, "halted");
    end
    check_store_count(0);
  endtask

  initial begin
    void'($urandom(32'h3163));
    reset = 1'b1;
    for (int i = 0; i < 256; i++) begin
      prog[i] = {6'h3F, 26'(i)};
    end
    reset_then_straight_line();
    repeat (3) arith_stores();
    load_and_zero_reg();
    branch_and_jump();
    call_and_return();
    halt_freezes_fetch();
    check_bit(we_in_reset, 1'b0, "dmem_we seen in reset");
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

/* src/cpu_top.sv */
// Core top level. Instruction and data memories sit outside and reply in the same cycle.
`timescale 1ns/100ps

module cpu_top (
  input  logic           clk,
  input  logic           reset,
  input  cpu_pkg::word_t imem_data,
  input  cpu_pkg::word_t dmem_rdata,
  output cpu_pkg::word_t imem_addr,
  output cpu_pkg::word_t dmem_addr,
  output cpu_pkg::word_t dmem_wdata,
  output logic           dmem_we,
  output logic           halted
);
  import cpu_pkg::*;

  opcode_t    opcode;
  funct_t     funct;
  alu_class_t alu_class;
  alu_op_t    alu_op;
  logic       reg_dst, alu_src, mem_to_reg, reg_write, mem_write;
  logic       branch, jump, link, jump_reg, pc_hold;

  // ---------------------------------------------------------------------
  // Control
  // ---------------------------------------------------------------------
  main_decoder u_main_decoder (
    .opcode (opcode), .reset (reset),
    .reg_dst (reg_dst), .alu_src (alu_src), .mem_to_reg (mem_to_reg),
    .reg_write (reg_write), .mem_write (mem_write), .branch (branch),
    .jump (jump), .link (link), .jump_reg (jump_reg),
    .pc_hold (pc_hold), .halted (halted), .alu_class (alu_class)
  );

  alu_decoder u_alu_decoder (.alu_class (alu_class), .funct (funct), .alu_op (alu_op));

  // Datapath and memory ports
  datapath u_datapath (
    .clk (clk), .reset (reset),
    .reg_dst (reg_dst), .alu_src (alu_src), .mem_to_reg (mem_to_reg),
    .reg_write (reg_write), .mem_write (mem_write), .branch (branch),
    .jump (jump), .link (link), .jump_reg (jump_reg), .pc_hold (pc_hold),
    .alu_op (alu_op), .imem_data (imem_data), .dmem_rdata (dmem_rdata),
    .opcode (opcode), .funct (funct), .imem_addr (imem_addr),
    .dmem_addr (dmem_addr), .dmem_wdata (dmem_wdata), .dmem_we (dmem_we)
  );

endmodule

/* src/datapath.sv */
// Single-cycle datapath. Memories are outside and must answer combinationally in the same cycle.
`timescale 1ns/100ps

module datapath (
  input  logic              clk,
  input  logic              reset,
  input  logic              reg_dst,
  input  logic              alu_src,
  input  logic              mem_to_reg,
  input  logic              reg_write,
  input  logic              mem_write,
  input  logic              branch,
  input  logic              jump,
  input  logic              link,
  input  logic              jump_reg,
  input  logic              pc_hold,
  input  cpu_pkg::alu_op_t  alu_op,
  input  cpu_pkg::word_t    imem_data,
  input  cpu_pkg::word_t    dmem_rdata,
  output cpu_pkg::opcode_t  opcode,
  output cpu_pkg::funct_t   funct,
  output cpu_pkg::word_t    imem_addr,
  output cpu_pkg::word_t    dmem_addr,
  output cpu_pkg::word_t    dmem_wdata,
  output logic              dmem_we
);
  import cpu_pkg::*;

  // ---------------------------------------------------------------------
  // Instruction fields
  // ---------------------------------------------------------------------
  reg_addr_t               rs;
  reg_addr_t               rt;
  reg_addr_t               rd;
  logic [15:0]             imm;
  logic [JUMP_INDEX_W-1:0] jump_index;
  word_t                   imm_ext;    // Sign-extended immediate

  word_t     pc_plus4;
  word_t     rs_data;
  word_t     rt_data;
  word_t     alu_b;
  word_t     alu_result;
  logic      alu_zero;
  reg_addr_t write_addr;
  word_t     write_data;

  assign opcode     = imem_data[31:26];
  assign rs         = imem_data[25:21];
  assign rt         = imem_data[20:16];
  assign rd         = imem_data[15:11];
  assign imm        = imem_data[15:0];
  assign jump_index = imem_data[JUMP_INDEX_W-1:0];
  assign funct      = imem_data[5:0];
  assign imm_ext    = {{(WORD_W-16){imm[15]}}, imm};

  pc_unit u_pc_unit (
    .clk           (clk),
    .reset         (reset),
    .hold          (pc_hold),
    .branch_taken  (branch & alu_zero), // beq on equal operands
    .jump          (jump),
    .jump_reg      (jump_reg),
    .branch_offset (imm_ext),
    .jump_index    (jump_index),
    .reg_target    (rs_data),
    .pc            (imem_addr),
    .pc_plus4      (pc_plus4)
  );

  // Destination is rt, rd or ra for jal
  assign write_addr = link ? REG_RA : (reg_dst ? rd : rt);
  // Write-back select with link first
  assign write_data = link ? pc_plus4 : (mem_to_reg ? dmem_rdata : alu_result);

  reg_file u_reg_file (
    .clk        (clk),
    .reset      (reset),
    .write_en   (reg_write),
    .read_addr1 (rs),
    .read_addr2 (rt),
    .write_addr (write_addr),
    .write_data (write_data),
    .read_data1 (rs_data),
    .read_data2 (rt_data)
  );

  assign alu_b = alu_src ? imm_ext : rt_data; // Immediate or register

  alu u_alu (
    .a      (rs_data),
    .b      (alu_b),
    .op     (alu_op),
    .result (alu_result),
    .zero   (alu_zero)
  );

  // Data memory port
  assign dmem_addr  = alu_result;
  assign dmem_wdata = rt_data;   // sw stores rt
  assign dmem_we    = mem_write;

endmodule

/* src/pc_unit.sv */
// Program counter and next address. Priority is jr, then j or jal, then taken beq, then pc+4.
`timescale 1ns/100ps

module pc_unit (
  input  logic                              clk,
  input  logic                              reset,
  input  logic                              hold,
  input  logic                              branch_taken,
  input  logic                              jump,
  input  logic                              jump_reg,
  input  cpu_pkg::word_t                    branch_offset,
  input  logic [cpu_pkg::JUMP_INDEX_W-1:0]  jump_index,
  input  cpu_pkg::word_t                    reg_target,
  output cpu_pkg::word_t                    pc,
  output cpu_pkg::word_t                    pc_plus4
);
  import cpu_pkg::*;

  word_t branch_target; // pc_plus4 plus offset in words
  word_t jump_target;   // Region of pc_plus4 with the index
  word_t pc_next;

  // ---------------------------------------------------------------------
  // Target adders
  // ---------------------------------------------------------------------
  assign pc_plus4      = pc + PC_STEP;
  assign branch_target = pc_plus4 + {branch_offset[WORD_W-3:0], 2'b00};
  assign jump_target   = {pc_plus4[WORD_W-1:WORD_W-4], jump_index, 2'b00};

  always_comb begin
    if (jump_reg) begin
      pc_next = reg_target;     // jr uses rs
    end else if (jump) begin
      pc_next = jump_target;    // j and jal
    end else if (branch_taken) begin
      pc_next = branch_target;
    end else begin
      pc_next = pc_plus4;       // Straight-line code
    end
  end

  // PC register, frozen on halt
  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= RESET_PC;
    end else if (!hold) begin
      pc <= pc_next;
    end
  end

endmodule

/* src/reg_file.sv */
// 32x32 register file with edge writes and combinational reads. Register 0 always reads 0.
`timescale 1ns/100ps

module reg_file (
  input  logic               clk,
  input  logic               reset,
  input  logic               write_en,
  input  cpu_pkg::reg_addr_t read_addr1,
  input  cpu_pkg::reg_addr_t read_addr2,
  input  cpu_pkg::reg_addr_t write_addr,
  input  cpu_pkg::word_t     write_data,
  output cpu_pkg::word_t     read_data1,
  output cpu_pkg::word_t     read_data2
);
  import cpu_pkg::*;

  word_t regs [REG_COUNT]; // Register array

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < REG_COUNT; i++) begin
        regs[i] <= '0; // Clear everything
      end
    end else if (write_en && (write_addr != REG_ZERO)) begin
      regs[write_addr] <= write_data; // r0 write dropped
    end
  end

  // Reads bypass the array for r0
  assign read_data1 = (read_addr1 == REG_ZERO) ? '0 : regs[read_addr1];
  assign read_data2 = (read_addr2 == REG_ZERO) ? '0 : regs[read_addr2];

endmodule

/* src/alu.sv */
// 32-bit ALU. slt uses the raw sign of a minus b and is wrong when the subtraction overflows.
`timescale 1ns/100ps

module alu (
  input  cpu_pkg::word_t   a,
  input  cpu_pkg::word_t   b,
  input  cpu_pkg::alu_op_t op,
  output cpu_pkg::word_t   result,
  output logic             zero
);
  import cpu_pkg::*;

  word_t sum;  // a plus b
  word_t diff; // a minus b for sub and slt

  assign sum  = a + b;
  assign diff = a - b;

  always_comb begin
    case (op)
      ALU_AND: result = a & b;
      ALU_OR:  result = a | b;
      ALU_ADD: result = sum;
      ALU_SUB: result = diff;
      ALU_SLT: result = {{(WORD_W-1){1'b0}}, diff[WORD_W-1]}; // Sign bit only
      default: result = '0; // ALU_NONE and unused codes
    endcase
  end

  // Equal compare for beq
  assign zero = (result == '0);

endmodule

/* src/alu_decoder.sv */
// ALU class plus funct to ALU operation. An unknown R-type funct yields a zero result.
`timescale 1ns/100ps

module alu_decoder (
  input  cpu_pkg::alu_class_t alu_class,
  input  cpu_pkg::funct_t     funct,
  output cpu_pkg::alu_op_t    alu_op
);
  import cpu_pkg::*;

  always_comb begin
    case (alu_class)
      ALU_CLASS_ADD: alu_op = ALU_ADD; // lw, sw, addi
      ALU_CLASS_SUB: alu_op = ALU_SUB; // beq
      ALU_CLASS_FUNCT: begin
        // R-type decode
        case (funct)
          FUNCT_ADD: alu_op = ALU_ADD;
          FUNCT_SUB: alu_op = ALU_SUB;
          FUNCT_AND: alu_op = ALU_AND;
          FUNCT_OR:  alu_op = ALU_OR;
          FUNCT_SLT: alu_op = ALU_SLT;
          default:   alu_op = ALU_NONE;
        endcase
      end
      default: alu_op = ALU_NONE; // Jumps and halt
    endcase
  end

endmodule

/* src/main_decoder.sv */
// Opcode to control word. Any opcode not in the table halts the core and blocks all writes.
`timescale 1ns/100ps

module main_decoder (
  input  cpu_pkg::opcode_t    opcode,
  input  logic                reset,
  output logic                reg_dst,
  output logic                alu_src,
  output logic                mem_to_reg,
  output logic                reg_write,
  output logic                mem_write,
  output logic                branch,
  output logic                jump,
  output logic                link,
  output logic                jump_reg,
  output logic                pc_hold,
  output logic                halted,
  output cpu_pkg::alu_class_t alu_class
);
  import cpu_pkg::*;

  always_comb begin
    // Defaults give a do-nothing word
    reg_dst    = 1'b0;
    alu_src    = 1'b0;
    mem_to_reg = 1'b0;
    reg_write  = 1'b0;
    mem_write  = 1'b0;
    branch     = 1'b0;
    jump       = 1'b0;
    link       = 1'b0;
    jump_reg   = 1'b0;
    pc_hold    = 1'b0;
    halted     = 1'b0;
    alu_class  = ALU_CLASS_NONE;

    case (opcode)
      OP_RTYPE: begin
        reg_dst   = 1'b1;
        reg_write = 1'b1;
        alu_class = ALU_CLASS_FUNCT;
      end
      OP_LW:    begin
        alu_src    = 1'b1; // Base plus offset
        mem_to_reg = 1'b1;
        reg_write  = 1'b1;
        alu_class  = ALU_CLASS_ADD;
      end
      OP_SW:    begin
        alu_src   = 1'b1;
        mem_write = 1'b1;
        alu_class = ALU_CLASS_ADD;
      end
      OP_BEQ:   begin
        branch    = 1'b1;
        alu_class = ALU_CLASS_SUB; // zero flag decides
      end
      OP_J:     jump = 1'b1;
      OP_JAL:   begin
        jump      = 1'b1;
        link      = 1'b1;
        reg_write = 1'b1; // pc_plus4 to ra
      end
      OP_JR:    jump_reg = 1'b1;                                      // Target is rs
      OP_ADDI:  begin
        alu_src   = 1'b1;
        reg_write = 1'b1;
        alu_class = ALU_CLASS_ADD;
      end
      default:  begin
        pc_hold = 1'b1;
        halted  = 1'b1; // Freeze fetch
      end
    endcase

    // No state changes while in reset
    if (reset) begin
      reg_write = 1'b0;
      mem_write = 1'b0;
    end
  end

endmodule

/* src/cpu_pkg.sv */
// Shared types and codes for the single-cycle core. Opcode 000101 is this design's own jr.
package cpu_pkg;

  // ---------------------------------------------------------------------
  // Widths
  // ---------------------------------------------------------------------
  localparam int WORD_W       = 32;
  localparam int REG_ADDR_W   = 5;
  localparam int OPCODE_W     = 6;
  localparam int FUNCT_W      = 6;
  localparam int ALU_CLASS_W  = 2;
  localparam int ALU_OP_W     = 4;
  localparam int JUMP_INDEX_W = 26; // j and jal target field
  localparam int REG_COUNT    = 32;

  // Plain vector types
  typedef logic [WORD_W-1:0]      word_t;
  typedef logic [REG_ADDR_W-1:0]  reg_addr_t;
  typedef logic [OPCODE_W-1:0]    opcode_t;
  typedef logic [FUNCT_W-1:0]     funct_t;
  typedef logic [ALU_CLASS_W-1:0] alu_class_t; // From main decoder
  typedef logic [ALU_OP_W-1:0]    alu_op_t;    // Into the ALU

  // ---------------------------------------------------------------------
  // Opcodes
  // ---------------------------------------------------------------------
  localparam opcode_t OP_RTYPE = 6'b000000;
  localparam opcode_t OP_LW    = 6'b100011;
  localparam opcode_t OP_SW    = 6'b101011;
  localparam opcode_t OP_BEQ   = 6'b000100;
  localparam opcode_t OP_J     = 6'b000010;
  localparam opcode_t OP_JAL   = 6'b000011;
  localparam opcode_t OP_JR    = 6'b000101; // Not the MIPS encoding
  localparam opcode_t OP_ADDI  = 6'b001000;

  // R-type funct codes
  localparam funct_t FUNCT_ADD = 6'b100000;
  localparam funct_t FUNCT_SUB = 6'b100010;
  localparam funct_t FUNCT_AND = 6'b100100;
  localparam funct_t FUNCT_OR  = 6'b100101;
  localparam funct_t FUNCT_SLT = 6'b101010;

  // ALU class from the main decoder
  localparam alu_class_t ALU_CLASS_ADD   = 2'b00; // Address calc and addi
  localparam alu_class_t ALU_CLASS_SUB   = 2'b01; // beq compare
  localparam alu_class_t ALU_CLASS_FUNCT = 2'b10; // Look at funct
  localparam alu_class_t ALU_CLASS_NONE  = 2'b11;

  // ---------------------------------------------------------------------
  // ALU operation codes
  // ---------------------------------------------------------------------
  localparam alu_op_t ALU_AND  = 4'b0000;
  localparam alu_op_t ALU_OR   = 4'b0001;
  localparam alu_op_t ALU_ADD  = 4'b0010;
  localparam alu_op_t ALU_SUB  = 4'b0110;
  localparam alu_op_t ALU_SLT  = 4'b0111;
  localparam alu_op_t ALU_NONE = 4'b1111; // Result forced to 0

  // Registers
  localparam reg_addr_t REG_ZERO = 5'd0;  // Hardwired zero
  localparam reg_addr_t REG_RA   = 5'd31; // Link register for jal

  // Fetch
  localparam word_t PC_STEP  = 32'd4; // Bytes per instruction
  localparam word_t RESET_PC = 32'd0; // First fetch address

endpackage
